/* Makefile */
VERILATOR := verilator
TOP       := ip_eth_tx_tb
FILELIST  := ip_eth_tx.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -Wno-fatal -Mdir $(OBJ_DIR) --top-module $(TOP)
PASS_MSG  := all tests passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/axis_skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer import ip_tx_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  beat_data_t fr_data,
    input  beat_keep_t fr_keep,
    input  logic       fr_last,
    input  logic       fr_valid,
    output logic       fr_ready,

    output beat_data_t out_data,
    output beat_keep_t out_keep,
    output logic       out_last,
    output logic       out_valid,
    input  logic       out_ready
);

    beat_data_t temp_data;
    beat_keep_t temp_keep;
    logic       temp_last;
    logic       temp_valid;
    logic       ready_early;
    logic       fr_xfer;
    logic       in_to_out;
    logic       in_to_temp;
    logic       temp_to_out;

    assign fr_xfer = fr_valid && fr_ready;

    // stay ready unless the temp entry is in use or about to be
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !fr_xfer));

    assign in_to_out = fr_ready && (out_ready || !out_valid);
    assign in_to_temp = fr_ready && !(out_ready || !out_valid);
    assign temp_to_out = !fr_ready && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
            fr_ready <= 1'b0;
        end else begin
            fr_ready <= ready_early;
            if (in_to_out) begin
                out_valid <= fr_valid;
            end else if (in_to_temp) begin
                temp_valid <= fr_valid;
            end else if (temp_to_out) begin
                out_valid <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_data <= fr_data;
            out_keep <= fr_keep;
            out_last <= fr_last;
        end else if (temp_to_out) begin
            out_data <= temp_data;
            out_keep <= temp_keep;
            out_last <= temp_last;
        end
        if (in_to_temp) begin
            temp_data <= fr_data;
            temp_keep <= fr_keep;
            temp_last <= fr_last;
        end
    end

endmodule

`default_nettype wire

/* hdl/ip_eth_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_eth_tx import ip_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // ipv4 header fields
    input  logic        hdr_valid,
    output logic        hdr_ready,
    input  logic [5:0]  ip_dscp,
    input  logic [1:0]  ip_ecn,
    input  ip_word_t    ip_length,
    input  ip_word_t    ip_identification,
    input  logic [2:0]  ip_flags,
    input  logic [12:0] ip_fragment_offset,
    input  logic [7:0]  ip_ttl,
    input  logic [7:0]  ip_protocol,
    input  ip_addr_t    ip_source_ip,
    input  ip_addr_t    ip_dest_ip,

    // payload stream
    input  beat_data_t  in_data,
    input  beat_keep_t  in_keep,
    input  logic        in_last,
    input  logic        in_valid,
    output logic        in_ready,

    // framed ipv4 packet
    output beat_data_t  out_data,
    output beat_keep_t  out_keep,
    output logic        out_last,
    output logic        out_valid,
    input  logic        out_ready
);

    logic        hdr_avail;
    logic        hdr_take;
    logic [5:0]  held_dscp;
    logic [1:0]  held_ecn;
    ip_word_t    held_length;
    ip_word_t    held_identification;
    logic [2:0]  held_flags;
    logic [12:0] held_fragment_offset;
    logic [7:0]  held_ttl;
    logic [7:0]  held_protocol;
    ip_addr_t    held_source_ip;
    ip_addr_t    held_dest_ip;
    ip_word_t    hdr_checksum;

    beat_data_t  fr_data;
    beat_keep_t  fr_keep;
    logic        fr_last;
    logic        fr_valid;
    logic        fr_ready;

    ip_hdr_capture u_capture (
        .clk                  (clk),
        .rst                  (rst),
        .hdr_valid            (hdr_valid),
        .hdr_ready            (hdr_ready),
        .ip_dscp              (ip_dscp),
        .ip_ecn               (ip_ecn),
        .ip_length            (ip_length),
        .ip_identification    (ip_identification),
        .ip_flags             (ip_flags),
        .ip_fragment_offset   (ip_fragment_offset),
        .ip_ttl               (ip_ttl),
        .ip_protocol          (ip_protocol),
        .ip_source_ip         (ip_source_ip),
        .ip_dest_ip           (ip_dest_ip),
        .hdr_avail            (hdr_avail),
        .hdr_take             (hdr_take),
        .held_dscp            (held_dscp),
        .held_ecn             (held_ecn),
        .held_length          (held_length),
        .held_identification  (held_identification),
        .held_flags           (held_flags),
        .held_fragment_offset (held_fragment_offset),
        .held_ttl             (held_ttl),
        .held_protocol        (held_protocol),
        .held_source_ip       (held_source_ip),
        .held_dest_ip         (held_dest_ip),
        .hdr_checksum         (hdr_checksum)
    );

    ip_payload_framer u_framer (
        .clk                  (clk),
        .rst                  (rst),
        .hdr_avail            (hdr_avail),
        .hdr_take             (hdr_take),
        .held_dscp            (held_dscp),
        .held_ecn             (held_ecn),
        .held_length          (held_length),
        .held_identification  (held_identification),
        .held_flags           (held_flags),
        .held_fragment_offset (held_fragment_offset),
        .held_ttl             (held_ttl),
        .held_protocol        (held_protocol),
        .held_source_ip       (held_source_ip),
        .held_dest_ip         (held_dest_ip),
        .hdr_checksum         (hdr_checksum),
        .in_data              (in_data),
        .in_keep              (in_keep),
        .in_last              (in_last),
        .in_valid             (in_valid),
        .in_ready             (in_ready),
        .fr_data              (fr_data),
        .fr_keep              (fr_keep),
        .fr_last              (fr_last),
        .fr_valid             (fr_valid),
        .fr_ready             (fr_ready)
    );

    axis_skid_buffer u_skid (
        .clk       (clk),
        .rst       (rst),
        .fr_data   (fr_data),
        .fr_keep   (fr_keep),
        .fr_last   (fr_last),
        .fr_valid  (fr_valid),
        .fr_ready  (fr_ready),
        .out_data  (out_data),
        .out_keep  (out_keep),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* hdl/ip_hdr_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_capture import ip_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        hdr_valid,
    output logic        hdr_ready,
    input  logic [5:0]  ip_dscp,
    input  logic [1:0]  ip_ecn,
    input  ip_word_t    ip_length,
    input  ip_word_t    ip_identification,
    input  logic [2:0]  ip_flags,
    input  logic [12:0] ip_fragment_offset,
    input  logic [7:0]  ip_ttl,
    input  logic [7:0]  ip_protocol,
    input  ip_addr_t    ip_source_ip,
    input  ip_addr_t    ip_dest_ip,

    output logic        hdr_avail,
    input  logic        hdr_take,
    output logic [5:0]  held_dscp,
    output logic [1:0]  held_ecn,
    output ip_word_t    held_length,
    output ip_word_t    held_identification,
    output logic [2:0]  held_flags,
    output logic [12:0] held_fragment_offset,
    output logic [7:0]  held_ttl,
    output logic [7:0]  held_protocol,
    output ip_addr_t    held_source_ip,
    output ip_addr_t    held_dest_ip,
    output ip_word_t    hdr_checksum
);

    logic        full;
    logic        full_next;
    logic        accept;
    logic [19:0] hdr_sum;
    logic [16:0] fold_first;
    ip_word_t    fold_second;

    assign accept = hdr_valid && hdr_ready;
    assign full_next = (full && !hdr_take) || accept;
    assign hdr_avail = full;

    // ready is registered so it stays low on the cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            hdr_ready <= 1'b0;
        end else begin
            full <= full_next;
            hdr_ready <= !full_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_dscp <= ip_dscp;
            held_ecn <= ip_ecn;
            held_length <= ip_length;
            held_identification <= ip_identification;
            held_flags <= ip_flags;
            held_fragment_offset <= ip_fragment_offset;
            held_ttl <= ip_ttl;
            held_protocol <= ip_protocol;
            held_source_ip <= ip_source_ip;
            held_dest_ip <= ip_dest_ip;
            // checksum word itself counts as zero
            hdr_sum <= 20'({IP_VERSION, IP_IHL, ip_dscp, ip_ecn}) +
                       20'(ip_length) +
                       20'(ip_identification) +
                       20'({ip_flags, ip_fragment_offset}) +
                       20'({ip_ttl, ip_protocol}) +
                       20'(ip_source_ip[31:16]) +
                       20'(ip_source_ip[15:0]) +
                       20'(ip_dest_ip[31:16]) +
                       20'(ip_dest_ip[15:0]);
        end
    end

    // end-around carry, two passes are enough for nine words
    assign fold_first = {1'b0, hdr_sum[15:0]} + {13'd0, hdr_sum[19:16]};
    assign fold_second = fold_first[15:0] + {15'd0, fold_first[16]};
    assign hdr_checksum = ~fold_second;

endmodule

`default_nettype wire

/* hdl/ip_payload_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_payload_framer import ip_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        hdr_avail,
    output logic        hdr_take,
    input  logic [5:0]  held_dscp,
    input  logic [1:0]  held_ecn,
    input  ip_word_t    held_length,
    input  ip_word_t    held_identification,
    input  logic [2:0]  held_flags,
    input  logic [12:0] held_fragment_offset,
    input  logic [7:0]  held_ttl,
    input  logic [7:0]  held_protocol,
    input  ip_addr_t    held_source_ip,
    input  ip_addr_t    held_dest_ip,
    input  ip_word_t    hdr_checksum,

    input  beat_data_t  in_data,
    input  beat_keep_t  in_keep,
    input  logic        in_last,
    input  logic        in_valid,
    output logic        in_ready,

    output beat_data_t  fr_data,
    output beat_keep_t  fr_keep,
    output logic        fr_last,
    output logic        fr_valid,
    input  logic        fr_ready
);

    framer_state_e state;
    framer_state_e next_state;

    // upper half of the previous input beat
    logic [HALF_W-1:0]     saved_data;
    logic [HALF_BYTES-1:0] saved_keep;
    logic                  save_en;

    logic                  upper_used;
    logic [HALF_W-1:0]     low_data;
    logic [HALF_BYTES-1:0] low_keep;
    beat_data_t            first_beat;
    beat_data_t            second_beat;

    // network order, most significant byte first on the wire
    function automatic logic [31:0] wire_order32(input logic [31:0] value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    function automatic logic [15:0] wire_order16(input logic [15:0] value);
        return {value[7:0], value[15:8]};
    endfunction

    assign first_beat = {held_fragment_offset[7:0],
                         held_flags, held_fragment_offset[12:8],
                         wire_order16(held_identification),
                         wire_order16(held_length),
                         held_dscp, held_ecn,
                         IP_VERSION, IP_IHL};

    assign second_beat = {wire_order32(held_source_ip),
                          wire_order16(hdr_checksum),
                          held_protocol,
                          held_ttl};

    assign upper_used = keep_to_count(in_keep) > 4'(HALF_BYTES);

    // lower output half comes from the header on the merge beat
    always_comb begin
        if (state == HDR_MERGE) begin
            low_data = wire_order32(held_dest_ip);
            low_keep = '1;
        end else begin
            low_data = saved_data;
            low_keep = saved_keep;
        end
    end

    always_comb begin
        next_state = state;
        fr_data = '0;
        fr_keep = '0;
        fr_last = 1'b0;
        fr_valid = 1'b0;
        in_ready = 1'b0;
        hdr_take = 1'b0;
        save_en = 1'b0;

        case (state)
            IDLE: begin
                if (hdr_avail) begin
                    next_state = HDR_FIRST;
                end
            end
            HDR_FIRST: begin
                fr_valid = 1'b1;
                fr_data = first_beat;
                fr_keep = '1;
                if (fr_ready) begin
                    next_state = HDR_SECOND;
                end
            end
            HDR_SECOND: begin
                fr_valid = 1'b1;
                fr_data = second_beat;
                fr_keep = '1;
                if (fr_ready) begin
                    next_state = HDR_MERGE;
                end
            end
            HDR_MERGE, PAYLOAD: begin
                in_ready = fr_ready;
                fr_valid = in_valid;
                fr_data = {in_data[HALF_W-1:0], low_data};
                fr_keep = {in_keep[HALF_BYTES-1:0], low_keep};
                fr_last = in_last && !upper_used;
                if (in_valid && fr_ready) begin
                    save_en = 1'b1;
                    // header register is free once destination address is out
                    hdr_take = (state == HDR_MERGE);
                    if (!in_last) begin
                        next_state = PAYLOAD;
                    end else if (upper_used) begin
                        next_state = FLUSH;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            FLUSH: begin
                fr_valid = 1'b1;
                fr_data = {{HALF_W{1'b0}}, saved_data};
                fr_keep = {{HALF_BYTES{1'b0}}, saved_keep};
                fr_last = 1'b1;
                if (fr_ready) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (save_en) begin
            saved_data <= in_data[DATA_W-1:HALF_W];
            saved_keep <= in_keep[DATA_BYTES-1:HALF_BYTES];
        end
    end

endmodule

`default_nettype wire

/* hdl/ip_tx_pkg.sv */
`default_nettype none

package ip_tx_pkg;

    // datapath geometry
    localparam int DATA_BYTES = 8;
    localparam int DATA_W = DATA_BYTES * 8;
    localparam int HALF_BYTES = DATA_BYTES / 2;
    localparam int HALF_W = DATA_W / 2;

    // fixed ipv4 header fields, no options supported
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;
    localparam int IP_HDR_BYTES = 20;

    // byte 0 goes out first on the wire
    typedef logic [DATA_W-1:0] beat_data_t;
    typedef logic [DATA_BYTES-1:0] beat_keep_t;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ip_word_t;

    typedef enum logic [2:0] {
        IDLE,
        HDR_FIRST,
        HDR_SECOND,
        // destination address plus first four payload bytes
        HDR_MERGE,
        PAYLOAD,
        // leftover upper-half bytes of the final input beat
        FLUSH
    } framer_state_e;

    // byte count of a contiguous keep
    function automatic logic [$clog2(DATA_BYTES):0] keep_to_count(input beat_keep_t keep);
        logic [$clog2(DATA_BYTES):0] count;
        count = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (keep[i]) begin
                count = count + 1'b1;
            end
        end
        return count;
    endfunction

endpackage

`default_nettype wire

/* ip_eth_tx.f */
hdl/ip_tx_pkg.sv
hdl/ip_hdr_capture.sv
hdl/ip_payload_framer.sv
hdl/axis_skid_buffer.sv
hdl/ip_eth_tx.sv
sim/ip_eth_tx_asserts.sv
sim/ip_eth_tx_tb.sv

/* sim/ip_eth_tx_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_eth_tx_asserts import ip_tx_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       hdr_ready,
    input logic       in_ready,
    input beat_data_t out_data,
    input beat_keep_t out_keep,
    input logic       out_last,
    input logic       out_valid,
    input logic       out_ready
);

    // a stalled output beat stays put
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) &&
            $stable(out_keep) && $stable(out_last))
        else $error("output beat changed while stalled");

    // keep runs from bit 0 without holes
    keep_shape: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (out_keep != '0) &&
            ((out_keep & beat_keep_t'(out_keep + beat_keep_t'(1))) == '0))
        else $error("output keep is empty or not contiguous");

    keep_full: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_last |-> out_keep == '1)
        else $error("output keep not full on a beat other than the last");

    // skip the first edge, flops are still unknown there
    reset_quiet: assert property (@(posedge clk)
        rst ##1 rst |-> !hdr_ready && !in_ready && !out_valid)
        else $error("handshake outputs active during reset");

endmodule

bind ip_eth_tx ip_eth_tx_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .hdr_ready (hdr_ready),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_keep  (out_keep),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

/* sim/ip_eth_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_eth_tx_tb import ip_tx_pkg::*; ();

    localparam int NUM_FRAMES = 50;
    localparam int MAX_PAYLOAD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT = 2000;
    localparam int STALL_LEN = 1024;

    logic        clk;
    logic        rst;
    logic        hdr_valid;
    logic        hdr_ready;
    logic [5:0]  ip_dscp;
    logic [1:0]  ip_ecn;
    ip_word_t    ip_length;
    ip_word_t    ip_identification;
    logic [2:0]  ip_flags;
    logic [12:0] ip_fragment_offset;
    logic [7:0]  ip_ttl;
    logic [7:0]  ip_protocol;
    ip_addr_t    ip_source_ip;
    ip_addr_t    ip_dest_ip;
    beat_data_t  in_data;
    beat_keep_t  in_keep;
    logic        in_last;
    logic        in_valid;
    logic        in_ready;
    beat_data_t  out_data;
    beat_keep_t  out_keep;
    logic        out_last;
    logic        out_valid;
    logic        out_ready;

    integer seed;
    int     data_errors = 0;
    int     keep_errors = 0;
    int     last_errors = 0;
    int     reset_errors = 0;
    int     timeout_errors = 0;
    int     extra_beats = 0;
    int     stall_idx = 0;
    bit     abort = 1'b0;

    // per frame stimulus, header fields packed in port order
    logic [135:0] fields_mem [NUM_FRAMES];
    logic [7:0]   payload_mem [NUM_FRAMES][MAX_PAYLOAD];
    int           payload_len [NUM_FRAMES];
    logic [1:0]   hdr_gap [NUM_FRAMES];
    logic [15:0]  beat_gaps [NUM_FRAMES];
    logic         stall_pattern [STALL_LEN];
    logic [7:0]   expected_q [$];

    ip_eth_tx u_ip_eth_tx (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random sink back-pressure
    always @(posedge clk) begin
        if (rst) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= stall_pattern[stall_idx];
            stall_idx <= (stall_idx + 1) % STALL_LEN;
        end
    end

    task automatic check_data(input beat_data_t actual, input beat_data_t expected,
                              input string what);
        if (actual !== expected) begin
            data_errors++;
            $display("mismatch at %0t: %s data %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_keep(input beat_keep_t actual, input beat_keep_t expected,
                              input string what);
        if (actual !== expected) begin
            keep_errors++;
            $display("mismatch at %0t: %s keep %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_last(input bit actual, input bit expected, input string what);
        if (actual !== expected) begin
            last_errors++;
            $display("mismatch at %0t: %s last %0b, expected %0b", $time, what, actual, expected);
        end
    endtask

    task automatic check_low(input logic actual, input string what);
        if (actual !== 1'b0) begin
            reset_errors++;
            $display("mismatch at %0t: %s is not low around reset", $time, what);
        end
    endtask

    // wire bytes of one frame, header first
    task automatic build_expected(input int f);
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        ip_word_t    length;
        ip_word_t    ident;
        logic [2:0]  flags;
        logic [12:0] frag;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        ip_addr_t    src;
        ip_addr_t    dst;
        logic [31:0] sum;
        ip_word_t    csum;
        {dscp, ecn, length, ident, flags, frag, ttl, proto, src, dst} = fields_mem[f];
        expected_q.delete();
        expected_q.push_back({IP_VERSION, IP_IHL});
        expected_q.push_back({dscp, ecn});
        expected_q.push_back(length[15:8]);
        expected_q.push_back(length[7:0]);
        expected_q.push_back(ident[15:8]);
        expected_q.push_back(ident[7:0]);
        expected_q.push_back({flags, frag[12:8]});
        expected_q.push_back(frag[7:0]);
        expected_q.push_back(ttl);
        expected_q.push_back(proto);
        // checksum slot is zero while summing
        expected_q.push_back(8'h00);
        expected_q.push_back(8'h00);
        for (int i = 3; i >= 0; i--) begin
            expected_q.push_back(src[8*i +: 8]);
        end
        for (int i = 3; i >= 0; i--) begin
            expected_q.push_back(dst[8*i +: 8]);
        end
        sum = '0;
        for (int i = 0; i < IP_HDR_BYTES; i += 2) begin
            sum = sum + 32'({expected_q[i], expected_q[i+1]});
        end
        while (sum[31:16] != 16'd0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        csum = ~sum[15:0];
        expected_q[10] = csum[15:8];
        expected_q[11] = csum[7:0];
        for (int i = 0; i < payload_len[f]; i++) begin
            expected_q.push_back(payload_mem[f][i]);
        end
    endtask

    task automatic wait_header_accept(output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            ok = hdr_ready;
        end
        if (ok) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_payload_accept(output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            ok = in_ready;
        end
        if (ok) begin
            @(posedge clk);
        end
    endtask

    // a beat leaves on the edge after a negedge with valid and ready
    task automatic wait_output_beat(output bit got);
        int waited;
        waited = 0;
        got = 1'b0;
        while (!got && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            got = out_valid && out_ready;
        end
    endtask

    task automatic send_headers();
        bit ok;
        @(posedge clk);
        for (int f = 0; f < NUM_FRAMES && !abort; f++) begin
            hdr_valid <= 1'b0;
            repeat (hdr_gap[f]) @(posedge clk);
            {ip_dscp, ip_ecn, ip_length, ip_identification, ip_flags, ip_fragment_offset,
             ip_ttl, ip_protocol, ip_source_ip, ip_dest_ip} <= fields_mem[f];
            hdr_valid <= 1'b1;
            wait_header_accept(ok);
            if (!ok) begin
                $display("timeout: header of frame %0d was never accepted", f);
                timeout_errors++;
                abort = 1'b1;
            end
        end
        hdr_valid <= 1'b0;
    endtask

    task automatic send_payloads();
        int         beats;
        bit         ok;
        beat_data_t data;
        beat_keep_t keep;
        @(posedge clk);
        for (int f = 0; f < NUM_FRAMES && !abort; f++) begin
            beats = (payload_len[f] + DATA_BYTES - 1) / DATA_BYTES;
            for (int b = 0; b < beats && !abort; b++) begin
                in_valid <= 1'b0;
                repeat (beat_gaps[f][2*b +: 2]) @(posedge clk);
                data = '0;
                keep = '0;
                for (int i = 0; i < DATA_BYTES; i++) begin
                    if (b * DATA_BYTES + i < payload_len[f]) begin
                        data[8*i +: 8] = payload_mem[f][b * DATA_BYTES + i];
                        keep[i] = 1'b1;
                    end
                end
                in_data <= data;
                in_keep <= keep;
                in_last <= (b == beats - 1);
                in_valid <= 1'b1;
                wait_payload_accept(ok);
                if (!ok) begin
                    $display("timeout: payload beat %0d of frame %0d was never accepted", b, f);
                    timeout_errors++;
                    abort = 1'b1;
                end
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_frames();
        int         n;
        bit         got;
        beat_data_t exp_data;
        beat_data_t mask;
        beat_keep_t exp_keep;
        string      what;
        for (int f = 0; f < NUM_FRAMES && !abort; f++) begin
            build_expected(f);
            n = expected_q.size();
            for (int b = 0; b < (n + DATA_BYTES - 1) / DATA_BYTES && !abort; b++) begin
                exp_data = '0;
                exp_keep = '0;
                mask = '0;
                for (int i = 0; i < DATA_BYTES; i++) begin
                    if (b * DATA_BYTES + i < n) begin
                        exp_data[8*i +: 8] = expected_q[b * DATA_BYTES + i];
                        exp_keep[i] = 1'b1;
                        mask[8*i +: 8] = 8'hff;
                    end
                end
                wait_output_beat(got);
                if (!got) begin
                    $display("timeout: beat %0d of frame %0d never reached the output", b, f);
                    timeout_errors++;
                    abort = 1'b1;
                end else begin
                    what = $sformatf("frame %0d beat %0d", f, b);
                    // bytes outside keep carry no meaning
                    check_data(out_data & mask, exp_data, what);
                    check_keep(out_keep, exp_keep, what);
                    check_last(out_last, (b + 1) * DATA_BYTES >= n, what);
                end
            end
        end
    endtask

    initial begin
        logic [159:0] wide;
        int           total;
        seed = 32'hb9e3b2dc;
        rst = 1'b1;
        hdr_valid = 1'b0;
        {ip_dscp, ip_ecn, ip_length, ip_identification, ip_flags, ip_fragment_offset,
         ip_ttl, ip_protocol, ip_source_ip, ip_dest_ip} = '0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        wide = '0;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int i = 0; i < 5; i++) begin
                wide = {wide[127:0], $random(seed)};
            end
            fields_mem[f] = wide[135:0];
            // first 40 frames visit every length once
            if (f < MAX_PAYLOAD) begin
                payload_len[f] = (f * 7) % MAX_PAYLOAD + 1;
            end else begin
                payload_len[f] = {$random(seed)} % MAX_PAYLOAD + 1;
            end
            for (int i = 0; i < MAX_PAYLOAD; i++) begin
                payload_mem[f][i] = 8'($random(seed));
            end
            hdr_gap[f] = 2'($random(seed));
            beat_gaps[f] = 16'($random(seed)) & 16'h5555;
        end
        for (int i = 0; i < STALL_LEN; i++) begin
            stall_pattern[i] = ({$random(seed)} % 4) != 0;
        end

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_low(hdr_ready, "hdr_ready");
            check_low(in_ready, "in_ready");
            check_low(out_valid, "out_valid");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_low(hdr_ready, "hdr_ready");
        check_low(in_ready, "in_ready");
        check_low(out_valid, "out_valid");

        fork
            send_headers();
            send_payloads();
            check_frames();
        join

        // nothing may follow the last frame
        for (int i = 0; i < 20 && !abort && extra_beats == 0; i++) begin
            @(negedge clk);
            if (out_valid) begin
                extra_beats++;
                $display("unexpected output beat after the last frame at %0t", $time);
            end
        end

        total = data_errors + keep_errors + last_errors + reset_errors +
                timeout_errors + extra_beats;
        $display("errors: data %0d, keep %0d, last %0d, reset %0d, timeout %0d, extra %0d",
                 data_errors, keep_errors, last_errors, reset_errors,
                 timeout_errors, extra_beats);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
